// File: bench/rvCoreTb.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module rvCoreTb import rvIsaPkg::*, rvPipePkg::*; ();

    localparam int WAIT_LIMIT   = 200;  // cycles per wait loop
    localparam int QUIET_CYCLES = 30;   // request-free cycles that mean fetch has stalled

    logic    clk = 1'b0;
    logic    arstN;
    logic    imemReq;
    wordT    imemAddr;
    logic    imemAck = 1'b0;
    instrT   imemData = '0;
    logic    wbValid;
    wbTraceT wbTrace;
    logic    halted;

    instrT       progMem [64];
    int          progLen;
    logic [31:0] expPc [$];
    logic [31:0] expRd [$];
    logic [31:0] expData [$];

    logic [31:0] lcgState = 32'ha560;
    logic [2:0]  delayCnt;
    logic        busy;

    rvCore rvCore_inst (
        .clk(clk), .arstN(arstN),
        .imemReq(imemReq), .imemAddr(imemAddr), .imemAck(imemAck), .imemData(imemData),
        .wbValid(wbValid), .wbTrace(wbTrace), .halted(halted)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one encoder per RV32I instruction format
    function automatic instrT encR(input int f7, input int rs2, input int rs1, input int f3,
                                   input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic instrT encI(input int imm, input int rs1, input int f3, input int rd,
                                   input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic instrT encU(input int imm20, input int rd, input int opc);
        return {imm20[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic instrT encB(input int off, input int rs1, input int rs2, input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic instrT encJ(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input instrT word);
        progMem[progLen] = word;
        progLen++;
    endtask

    task automatic addExpected(input int pc, input int rd, input logic [31:0] data);
        expPc.push_back(32'(pc));
        expRd.push_back(32'(rd));
        expData.push_back(data);
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                              $time, what, got, exp));
        end
    endtask

    task automatic loadProgram();
        progLen = 0;
        for (int i = 0; i < 64; i++) progMem[i] = encI(i, 0, 0, 0, 'h13);  // addi x0, x0, i
        emit(encI(5, 0, 0, 1, 'h13));          // 0x00 addi x1, x0, 5
        emit(encI(-3, 0, 0, 2, 'h13));         // addi x2, x0, -3
        emit(encR(0, 2, 1, 0, 3));             // add x3
        emit(encR('h20, 2, 1, 0, 4));          // sub x4
        emit(encI(3, 1, 1, 5, 'h13));          // 0x10 slli x5
        emit(encI('h401, 2, 5, 6, 'h13));      // srai x6
        emit(encI(28, 2, 5, 7, 'h13));         // srli x7
        emit(encR(0, 1, 2, 2, 8));             // slt x8
        emit(encR(0, 1, 2, 3, 9));             // 0x20 sltu x9
        emit(encR(0, 2, 1, 4, 10));
        emit(encR(0, 2, 1, 6, 11));
        emit(encR(0, 2, 1, 7, 12));
        emit(encU('h12345, 13, 'h37));         // 0x30 lui
        emit(encU(1, 14, 'h17));               // auipc
        emit(encI(7, 1, 0, 0, 'h13));          // write to x0
        emit(encR(0, 1, 0, 0, 15));            // reads x0
        emit(encB(8, 1, 2, 0));                // 0x40 beq not taken
        emit(encB(12, 1, 1, 0));               // beq taken to 0x50
        emit(encI(1, 0, 0, 16, 'h13));
        emit(encI(2, 0, 0, 16, 'h13));
        emit(encB(8, 1, 2, 1));                // 0x50 bne
        emit(encI(3, 0, 0, 16, 'h13));
        emit(encB(8, 2, 1, 4));                // blt
        emit(encI(4, 0, 0, 16, 'h13));
        emit(encB(8, 1, 2, 5));                // 0x60 bge
        emit(encI(5, 0, 0, 16, 'h13));
        emit(encB(8, 1, 2, 6));                // bltu
        emit(encI(6, 0, 0, 16, 'h13));
        emit(encB(8, 2, 1, 7));                // 0x70 bgeu
        emit(encI(7, 0, 0, 16, 'h13));
        emit(encB(8, 1, 1, 1));                // bne not taken
        emit(encJ(12, 17));                    // jal x17 to 0x88
        emit(encI(8, 0, 0, 16, 'h13));         // 0x80
        emit(encI(9, 0, 0, 16, 'h13));
        emit(encI(153, 0, 0, 18, 'h13));       // 0x88 odd base for jalr
        emit(encI(0, 18, 0, 19, 'h67));        // jalr x19 to 0x98
        emit(encI(10, 0, 0, 16, 'h13));        // 0x90
        emit(encI(11, 0, 0, 16, 'h13));
        for (int i = 0; i < 8; i++) emit(encI(1, 20, 0, 20, 'h13));  // straight-line run
        emit(encR(0, 17, 20, 0, 21));          // 0xb8
        emit(32'h0000_0073);                   // ecall
        emit(encI(9, 0, 0, 22, 'h13));         // never retires
    endtask

    task automatic loadExpected();
        addExpected('h00, 1, 32'h0000_0005);
        addExpected('h04, 2, 32'hFFFF_FFFD);
        addExpected('h08, 3, 32'h0000_0002);
        addExpected('h0C, 4, 32'h0000_0008);
        addExpected('h10, 5, 32'h0000_0028);
        addExpected('h14, 6, 32'hFFFF_FFFE);
        addExpected('h18, 7, 32'h0000_000F);
        addExpected('h1C, 8, 32'h0000_0001);
        addExpected('h20, 9, 32'h0000_0000);
        addExpected('h24, 10, 32'hFFFF_FFF8);
        addExpected('h28, 11, 32'hFFFF_FFFD);
        addExpected('h2C, 12, 32'h0000_0005);
        addExpected('h30, 13, 32'h1234_5000);
        addExpected('h34, 14, 32'h0000_1034);
        addExpected('h3C, 15, 32'h0000_0005);
        addExpected('h7C, 17, 32'h0000_0080);
        addExpected('h88, 18, 32'h0000_0099);
        addExpected('h8C, 19, 32'h0000_0090);
        for (int i = 0; i < 8; i++) addExpected('h98 + 4 * i, 20, 32'(i + 1));
        addExpected('hB8, 21, 32'h0000_0088);
    endtask

    // memory side of the four-phase handshake
    always @(posedge clk) begin
        if (!arstN) begin
            imemAck <= 1'b0;
            busy    <= 1'b0;
        end else if (imemAck) begin
            if (!imemReq) imemAck <= 1'b0;
        end else if (busy) begin
            if (delayCnt == 3'd0) begin
                imemData <= progMem[imemAddr[7:2]];
                imemAck  <= 1'b1;
                busy     <= 1'b0;
            end else begin
                delayCnt <= delayCnt - 3'd1;
            end
        end else if (imemReq) begin
            lcgState = lcgNext(lcgState);
            delayCnt <= lcgState[18:16] % 3'd6;   // 0 to 5 cycles
            busy     <= 1'b1;
        end
    end

    task automatic waitWriteBack(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wbValid) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                failRun($sformatf("timed out waiting for write-back number %0d", idx));
            end
            @(negedge clk);
        end
    endtask

    task automatic waitHalt();
        int cycles;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            if (wbValid) failRun("unexpected write-back after the last expected one");
            cycles++;
            if (cycles > WAIT_LIMIT) failRun("timed out waiting for the core to halt");
        end
    endtask

    // halted core stops popping, so the queue fills and fetch must stall
    task automatic waitFetchStall();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            if (wbValid) failRun("write-back seen after ECALL halted the core");
            if (!halted) failRun("halted dropped after ECALL");
            quiet = imemReq ? 0 : quiet + 1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                failRun("timed out waiting for fetch to stall on a full queue");
            end
        end
    endtask

    initial begin
        #100000;
        failRun("simulation watchdog expired before the test finished");
    end

    initial begin
        arstN = 1'b0;
        loadProgram();
        loadExpected();
        repeat (5) @(posedge clk);
        arstN <= 1'b1;

        for (int i = 0; i < expPc.size(); i++) begin
            waitWriteBack(i);
            checkValue($sformatf("entry %0d pc", i), wbTrace.pc, expPc[i]);
            checkValue($sformatf("entry %0d rd", i), 32'(wbTrace.rd), expRd[i]);
            checkValue($sformatf("entry %0d data", i), wbTrace.data, expData[i]);
        end

        waitHalt();
        waitFetchStall();
        // words after the ecall at 0xbc fill every queue entry
        checkValue("last fetch address", imemAddr, 32'hBC + 4 * `QUEUE_DEPTH);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: bench/rvCore_asserts.sv
`timescale 1ns/100ps

module rvCoreAsserts import rvIsaPkg::*, rvPipePkg::*; (
    input logic     clk,
    input logic     arstN,
    input logic     imemReq,
    input wordT     imemAddr,
    input logic     imemAck,
    input logic     push,
    input logic     full,
    input redirectT redirect,
    input logic     empty
);

    // address held while waiting for the memory
    addrStable: assert property (@(posedge clk) disable iff (!arstN)
        (imemReq && !imemAck) |=> $stable(imemAddr))
        else $error("imemAddr changed during an open request");

    reqAfterAckLow: assert property (@(posedge clk) disable iff (!arstN)
        $rose(imemReq) |-> !imemAck)
        else $error("imemReq rose while imemAck was high");

    noPushWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        push |-> !full)
        else $error("push into a full queue");

    // a push that is not flushed leaves at least one entry
    pushKept: assert property (@(posedge clk) disable iff (!arstN)
        (push && !redirect.valid) |=> !empty)
        else $error("queue empty right after an accepted push");

endmodule

bind rvCore rvCoreAsserts rvCoreAsserts_inst (
    .clk(clk), .arstN(arstN), .imemReq(imemReq), .imemAddr(imemAddr), .imemAck(imemAck),
    .push(push), .full(full), .redirect(redirect), .empty(empty)
);

// File: logic/aluUnit.sv
`timescale 1ns/100ps

module aluUnit import rvIsaPkg::*; (
    input  wordT  a,
    input  wordT  b,
    input  aluOpE op,
    output wordT  result,
    output logic  isZero,
    output logic  lessSigned,
    output logic  lessUnsigned
);

    wordT       diff;
    logic       borrow;
    logic [4:0] shamt;

    assign {borrow, diff} = {1'b0, a} - {1'b0, b};
    assign shamt          = b[4:0];

    // flags for branch resolution, all from a - b
    assign isZero       = (diff == '0);
    assign lessUnsigned = borrow;
    assign lessSigned   = (a[$bits(wordT)-1] != b[$bits(wordT)-1]) ?
                          a[$bits(wordT)-1] : diff[$bits(wordT)-1];

    always_comb begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = diff;
            ALU_SLL:   result = a << shamt;
            ALU_SLT:   result = wordT'(lessSigned);
            ALU_SLTU:  result = wordT'(lessUnsigned);
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = $signed(a) >>> shamt;   // sign fill
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/100ps

module controlUnit import rvIsaPkg::*, rvPipePkg::*; (
    input  instrT instr,
    output ctrlT  ctrl
);

    logic [2:0] funct3;
    logic       altBit;     // funct7 bit 5

    assign funct3 = instr[14:12];
    assign altBit = instr[30];

    // shared by register and immediate ALU forms
    function automatic aluOpE decodeAluOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl            = '0;
        ctrl.rd         = instr[11:7];
        ctrl.rs1        = instr[19:15];
        ctrl.rs2        = instr[24:20];
        ctrl.immKind    = IMM_I;
        ctrl.aSrc       = A_REG;
        ctrl.bSrc       = B_REG;
        ctrl.aluOp      = ALU_ADD;
        ctrl.branchKind = BR_NONE;

        case (opcodeE'(instr[6:0]))
            OPC_OP: begin
                ctrl.aluOp    = decodeAluOp(funct3, altBit);
                ctrl.regWrite = 1'b1;
            end
            OPC_OP_IMM: begin
                // bit 30 is part of the immediate except for SRAI
                ctrl.aluOp    = decodeAluOp(funct3, altBit && funct3 == 3'b101);
                ctrl.bSrc     = B_IMM;
                ctrl.regWrite = 1'b1;
            end
            OPC_LUI: begin
                ctrl.immKind  = IMM_U;
                ctrl.bSrc     = B_IMM;
                ctrl.aluOp    = ALU_PASSB;
                ctrl.regWrite = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.immKind  = IMM_U;
                ctrl.aSrc     = A_PC;
                ctrl.bSrc     = B_IMM;
                ctrl.regWrite = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                ctrl.immKind    = (instr[3]) ? IMM_J : IMM_I;   // bit 3 set only for JAL
                ctrl.aSrc       = A_PC;     // alu builds the link value pc + 4
                ctrl.bSrc       = B_FOUR;
                ctrl.branchKind = (instr[3]) ? BR_JAL : BR_JALR;
                ctrl.regWrite   = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.immKind = IMM_B;
                ctrl.aluOp   = ALU_SUB;
                case (funct3)
                    3'b000:  ctrl.branchKind = BR_EQ;
                    3'b001:  ctrl.branchKind = BR_NE;
                    3'b100:  ctrl.branchKind = BR_LT;
                    3'b101:  ctrl.branchKind = BR_GE;
                    3'b110:  ctrl.branchKind = BR_LTU;
                    3'b111:  ctrl.branchKind = BR_GEU;
                    default: ctrl.branchKind = BR_NONE;
                endcase
            end
            OPC_SYSTEM: begin
                ctrl.isHalt = (instr[31:7] == '0);  // ECALL only
            end
            default: ;  // unsupported opcodes retire as no-ops
        endcase
    end

endmodule

// File: logic/executeStage.sv
`timescale 1ns/100ps

module executeStage import rvIsaPkg::*, rvPipePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        empty,
    input  fetchPacketT headPacket,
    output logic        pop,
    output redirectT    redirect,
    output logic        wbValid,
    output wbTraceT     wbTrace,
    output logic        halted
);

    ctrlT  ctrl;
    wordT  imm;
    wordT  rd1, rd2;
    wordT  opA, opB;
    wordT  aluResult;
    logic  isZero, lessSigned, lessUnsigned;
    logic  taken;
    wordT  target;
    logic  [31:0] ir;

    assign ir = headPacket.instr;

    // hold off while the queue is being flushed, and after ECALL
    assign pop = !empty && !halted && !redirect.valid;

    controlUnit controlUnit_inst (.instr(headPacket.instr), .ctrl(ctrl));

    regFile regFile_inst (
        .clk(clk), .arstN(arstN),
        .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd1(rd1), .rd2(rd2),
        .we(pop && ctrl.regWrite), .wrIdx(ctrl.rd), .wrData(aluResult)
    );

    always_comb begin
        case (ctrl.immKind)
            IMM_S:   imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            IMM_B:   imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            IMM_U:   imm = {ir[31:12], 12'b0};
            IMM_J:   imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default: imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    assign opA = (ctrl.aSrc == A_PC) ? headPacket.pc : rd1;
    assign opB = (ctrl.bSrc == B_IMM) ? imm : (ctrl.bSrc == B_FOUR) ? wordT'(4) : rd2;

    aluUnit aluUnit_inst (
        .a(opA), .b(opB), .op(ctrl.aluOp), .result(aluResult),
        .isZero(isZero), .lessSigned(lessSigned), .lessUnsigned(lessUnsigned)
    );

    always_comb begin
        case (ctrl.branchKind)
            BR_JAL, BR_JALR: taken = 1'b1;
            BR_EQ:   taken = isZero;
            BR_NE:   taken = !isZero;
            BR_LT:   taken = lessSigned;
            BR_GE:   taken = !lessSigned;
            BR_LTU:  taken = lessUnsigned;
            BR_GEU:  taken = !lessUnsigned;
            default: taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 cleared
    assign target = (ctrl.branchKind == BR_JALR) ? ((rd1 + imm) & ~wordT'(1))
                                                 : headPacket.pc + imm;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            redirect <= '0;
            wbValid  <= 1'b0;
            halted   <= 1'b0;
        end else begin
            redirect.valid  <= pop && taken;    // one-cycle pulse
            redirect.target <= target;
            wbValid         <= pop && ctrl.regWrite && ctrl.rd != '0;
            halted          <= halted || (pop && ctrl.isHalt);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wbTrace.pc   <= headPacket.pc;
            wbTrace.rd   <= ctrl.rd;
            wbTrace.data <= aluResult;
        end
    end

endmodule

// File: logic/fetchUnit.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module fetchUnit import rvIsaPkg::*, rvPipePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  redirectT    redirect,
    input  logic        full,
    output logic        imemReq,
    output wordT        imemAddr,
    input  logic        imemAck,
    input  instrT       imemData,
    output logic        push,
    output fetchPacketT pushPacket
);

    typedef enum logic [1:0] {IDLE, REQ, RELEASE} fetchStateE;

    fetchStateE state;
    wordT       pc;         // next address to fetch
    logic       stale;      // word in flight was requested before a redirect
    logic       keepWord;

    assign imemReq  = (state == REQ);
    assign keepWord = imemAck && !stale && !redirect.valid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= IDLE;
            pc       <= `RESET_PC;
            imemAddr <= `RESET_PC;
            stale    <= 1'b0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                IDLE: begin
                    // back-pressure: no new request while the queue is full
                    if (!full && !redirect.valid) begin
                        imemAddr <= pc;
                        state    <= REQ;
                    end
                end
                REQ: begin
                    if (imemAck) begin
                        push  <= keepWord;
                        stale <= 1'b0;
                        state <= RELEASE;
                    end else if (redirect.valid) begin
                        stale <= 1'b1;  // finish the transfer, drop the word
                    end
                end
                RELEASE: begin
                    if (!imemAck) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (redirect.valid) begin
                pc <= redirect.target;
            end else if (state == REQ && keepWord) begin
                pc <= imemAddr + wordT'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == REQ && imemAck) begin
            pushPacket.pc    <= imemAddr;
            pushPacket.instr <= imemData;
        end
    end

endmodule

// File: logic/instrQueue.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module instrQueue import rvPipePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        push,
    input  fetchPacketT pushPacket,
    input  logic        pop,
    input  logic        flush,
    output logic        full,
    output logic        empty,
    output fetchPacketT headPacket
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `QUEUE_DEPTH;

    fetchPacketT      mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic             doPush;
    logic             doPop;

    assign full   = (count == DEPTH);
    assign empty  = (count == '0);
    assign doPush = push && !full && !flush;   // flush wins over push
    assign doPop  = pop && !empty && !flush;

    assign headPacket = mem[rdPtr];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;    // wraps at depth
            if (doPop)  rdPtr <= rdPtr + 1'b1;
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) mem[wrPtr] <= pushPacket;
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/100ps

module regFile import rvIsaPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  regIdxT rs1,
    input  regIdxT rs2,
    output wordT   rd1,
    output wordT   rd2,
    input  logic   we,
    input  regIdxT wrIdx,
    input  wordT   wrData
);

    wordT regs [32];

    // x0 is hardwired
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (we && wrIdx != '0) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

// File: logic/rvCore.sv
`timescale 1ns/100ps

module rvCore import rvIsaPkg::*, rvPipePkg::*; (
    input  logic    clk,
    input  logic    arstN,
    output logic    imemReq,
    output wordT    imemAddr,
    input  logic    imemAck,
    input  instrT   imemData,
    output logic    wbValid,
    output wbTraceT wbTrace,
    output logic    halted
);

    redirectT    redirect;
    logic        full, empty;
    logic        push, pop;
    fetchPacketT pushPacket;
    fetchPacketT headPacket;

    fetchUnit fetchUnit_inst (
        .clk(clk), .arstN(arstN), .redirect(redirect), .full(full),
        .imemReq(imemReq), .imemAddr(imemAddr), .imemAck(imemAck), .imemData(imemData),
        .push(push), .pushPacket(pushPacket)
    );

    // redirect doubles as the queue flush
    instrQueue instrQueue_inst (
        .clk(clk), .arstN(arstN), .push(push), .pushPacket(pushPacket),
        .pop(pop), .flush(redirect.valid), .full(full), .empty(empty),
        .headPacket(headPacket)
    );

    executeStage executeStage_inst (
        .clk(clk), .arstN(arstN), .empty(empty), .headPacket(headPacket),
        .pop(pop), .redirect(redirect), .wbValid(wbValid), .wbTrace(wbTrace),
        .halted(halted)
    );

endmodule

// File: logic/rvIsaPkg.sv
`include "rv_config.svh"

package rvIsaPkg;

    typedef logic [`XLEN-1:0] wordT;    // data and addresses
    typedef logic [31:0]      instrT;
    typedef logic [4:0]       regIdxT;

    // supported major opcodes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB    // operand b straight through, for LUI
    } aluOpE;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immKindE;

    // nine kinds, so one bit wider than funct3
    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branchKindE;

    typedef enum logic {A_REG, A_PC} aSrcE;

    typedef enum logic [1:0] {B_REG, B_IMM, B_FOUR} bSrcE;

endpackage

// File: logic/rvPipePkg.sv
package rvPipePkg;

    import rvIsaPkg::*;

    // one fetched word and where it came from
    typedef struct packed {
        wordT  pc;
        instrT instr;
    } fetchPacketT;

    // decoded control bundle
    typedef struct packed {
        regIdxT     rd;
        regIdxT     rs1;
        regIdxT     rs2;
        immKindE    immKind;
        aSrcE       aSrc;
        bSrcE       bSrc;
        aluOpE      aluOp;
        branchKindE branchKind;
        logic       regWrite;
        logic       isHalt;     // ECALL
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT target;
    } redirectT;

    // one retired register write
    typedef struct packed {
        wordT   pc;
        regIdxT rd;
        wordT   data;
    } wbTraceT;

endpackage

// File: logic/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and address width
`define XLEN 32

// address of the first fetch after reset
`define RESET_PC 32'h0000_0000

// instruction queue entries, power of two
`define QUEUE_DEPTH 4

`endif

// File: run.sh
#!/bin/sh
# build and run the rvCore testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module rvCoreTb \
    -o rvCoreSim

./obj_dir/rvCoreSim

// File: src.f
+incdir+logic
logic/rvIsaPkg.sv
logic/rvPipePkg.sv
logic/fetchUnit.sv
logic/instrQueue.sv
logic/controlUnit.sv
logic/aluUnit.sv
logic/regFile.sv
logic/executeStage.sv
logic/rvCore.sv
bench/rvCore_asserts.sv
bench/rvCoreTb.sv
